/* include/intra_pred_consts.svh */
//****************************************
// sizes fixed by the H.264 4x4 intra path
// 4:2:0 only, chroma edges are half length
//****************************************
`ifndef INTRA_PRED_CONSTS_SVH
`define INTRA_PRED_CONSTS_SVH

`define IP_PIXEL_W    8   // bits per sample
`define IP_QUAD_N     4   // pixels per line-RAM word
`define IP_BLK_N      16  // luma edge / prediction block
`define IP_CHROMA_N   8   // chroma edge

`define IP_BLK_CNT_W  5
`define IP_PRELOAD_W  3

// block counter plane boundaries
`define IP_CB_FIRST   16
`define IP_CR_FIRST   20

`endif

/* source/intra_pred_pkg.sv */
//****************************************
// shared types for the intra predictor
// pixel 0 always sits in the low byte
//****************************************
`include "intra_pred_consts.svh"

package intra_pred_pkg;

	typedef logic [`IP_PIXEL_W-1:0] pixel_t;

	typedef struct packed {
		pixel_t p3;
		pixel_t p2;
		pixel_t p1;
		pixel_t p0;                                   // low byte, as in line RAM
	} quad_t;

	typedef pixel_t [`IP_BLK_N-1:0] pixel_blk_t;

	typedef enum logic [1:0] {
		PLANE_LUMA,
		PLANE_CB,
		PLANE_CR
	} plane_e;

	typedef enum logic [1:0] {
		PRED_NONE,
		PRED_COLUMN,
		PRED_DC
	} pred_cmd_e;

	typedef struct packed {
		pred_cmd_e cmd;
		logic [1:0] col;
		quad_t data;
	} pred_wr_t;

	typedef struct packed {
		logic wr;
		logic [1:0] addr;
		quad_t data;
	} quad_wr_t;

	typedef struct packed {
		plane_e target;
		quad_wr_t row;
	} left_wr_t;

	typedef struct packed {
		quad_t luma;
		quad_t cb;
		quad_t cr;
	} line_ram_t;

endpackage

/* source/intra_pred_block_buf.sv */
//****************************************
// 4x4 predicted pixel buffer, raster order
// col counts from the right: col 3 = left
//****************************************
`timescale 1ns/1ps
`include "intra_pred_consts.svh"

module intra_pred_block_buf (
	input logic clk,
	input logic rst_n,
	input logic ena,
	input intra_pred_pkg::pred_wr_t pred_wr,
	output intra_pred_pkg::pixel_blk_t intra_pred
);
	import intra_pred_pkg::*;

	pixel_blk_t pix_q;
	pixel_t [`IP_QUAD_N-1:0] col_pix;                // p0 is the top row
	logic [1:0] col_idx;

	assign col_pix = pred_wr.data;
	assign col_idx = 2'd3 - pred_wr.col;               // inverted column order

	//****************************************
	// write port
	//****************************************
	// one command per cycle, so DC fill and a column
	// write never compete for the buffer
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_q <= '0;
		end else if (ena) begin
			case (pred_wr.cmd)
				PRED_DC: begin
					pix_q <= {`IP_BLK_N{pred_wr.data.p0}};
				end
				PRED_COLUMN: begin
					for (int r = 0; r < `IP_QUAD_N; r++) begin
						pix_q[{2'(r), col_idx}] <= col_pix[r]; // row r, column col_idx
					end
				end
				default: begin
					pix_q <= pix_q;                        // PRED_NONE and unused code
				end
			endcase
		end
	end

	assign intra_pred = pix_q;

endmodule

/* source/intra_pred_up_nb.sv */
//****************************************
// upper neighbour row, luma + Cb + Cr
// preload counts down 4..1, wins over
// bottom row write-back in the same cycle
//****************************************
`timescale 1ns/1ps
`include "intra_pred_consts.svh"

module intra_pred_up_nb (
	input logic clk,
	input logic rst_n,
	input logic ena,
	input logic [`IP_PRELOAD_W-1:0] preload_counter,
	input intra_pred_pkg::line_ram_t line_ram,
	input intra_pred_pkg::quad_wr_t up_wr,
	input intra_pred_pkg::plane_e plane,
	output intra_pred_pkg::pixel_blk_t up_mb
);
	import intra_pred_pkg::*;

	pixel_blk_t luma_q;
	pixel_t [`IP_CHROMA_N-1:0] cb_q;
	pixel_t [`IP_CHROMA_N-1:0] cr_q;

	logic luma_pre;
	logic chroma_pre;
	logic [1:0] luma_slot;
	logic chroma_slot;

	//****************************************
	// preload decode
	//****************************************
	assign luma_pre = (preload_counter != '0) &&
		(preload_counter <= `IP_PRELOAD_W'(`IP_QUAD_N));
	assign luma_slot = 2'(`IP_PRELOAD_W'(`IP_QUAD_N) - preload_counter); // 4 -> 0, 1 -> 3

	assign chroma_pre = (preload_counter == `IP_PRELOAD_W'(1)) ||
		(preload_counter == `IP_PRELOAD_W'(2));
	assign chroma_slot = (preload_counter == `IP_PRELOAD_W'(1)); // 2 -> low quad

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			luma_q <= '0;
		end else if (ena && luma_pre) begin
			luma_q[{luma_slot, 2'b00} +: `IP_QUAD_N] <= line_ram.luma;
		end else if (ena && up_wr.wr) begin
			luma_q[{up_wr.addr, 2'b00} +: `IP_QUAD_N] <= up_wr.data; // bottom row of block above
		end
	end

	// chroma is only ever loaded from the line RAM
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cb_q <= '0;
			cr_q <= '0;
		end else if (ena && chroma_pre) begin
			cb_q[{chroma_slot, 2'b00} +: `IP_QUAD_N] <= line_ram.cb;
			cr_q[{chroma_slot, 2'b00} +: `IP_QUAD_N] <= line_ram.cr;
		end
	end

	//****************************************
	// plane select
	//****************************************
	always_comb begin
		up_mb = '0;                                    // upper half stays zero for chroma
		case (plane)
			PLANE_LUMA: begin
				up_mb = luma_q;
			end
			PLANE_CB: begin
				up_mb[`IP_CHROMA_N-1:0] = cb_q;
			end
			PLANE_CR: begin
				up_mb[`IP_CHROMA_N-1:0] = cr_q;
			end
			default: begin
				up_mb = '0;
			end
		endcase
	end

endmodule

/* source/intra_pred_left_nb.sv */
//****************************************
// left neighbour column, luma + Cb + Cr
// one write per cycle, chroma uses addr[0]
//****************************************
`timescale 1ns/1ps
`include "intra_pred_consts.svh"

module intra_pred_left_nb (
	input logic clk,
	input logic rst_n,
	input logic ena,
	input intra_pred_pkg::left_wr_t left_wr,
	input intra_pred_pkg::plane_e plane,
	output intra_pred_pkg::pixel_blk_t left_mb
);
	import intra_pred_pkg::*;

	pixel_blk_t luma_q;
	pixel_t [`IP_CHROMA_N-1:0] cb_q;
	pixel_t [`IP_CHROMA_N-1:0] cr_q;

	logic wr_en;
	logic [3:0] luma_base;
	logic [2:0] chroma_base;

	assign wr_en = ena && left_wr.row.wr;
	assign luma_base = {left_wr.row.addr, 2'b00};
	assign chroma_base = {left_wr.row.addr[0], 2'b00};

	//****************************************
	// right column write-back
	//****************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			luma_q <= '0;
			cb_q <= '0;
			cr_q <= '0;
		end else if (wr_en) begin
			case (left_wr.target)
				PLANE_LUMA: begin
					luma_q[luma_base +: `IP_QUAD_N] <= left_wr.row.data;
				end
				PLANE_CB: begin
					cb_q[chroma_base +: `IP_QUAD_N] <= left_wr.row.data;
				end
				PLANE_CR: begin
					cr_q[chroma_base +: `IP_QUAD_N] <= left_wr.row.data;
				end
				default: begin
					luma_q <= luma_q;                      // no plane, drop the write
				end
			endcase
		end
	end

	//****************************************
	// plane select
	//****************************************
	always_comb begin
		left_mb = '0;
		case (plane)
			PLANE_LUMA: begin
				left_mb = luma_q;
			end
			PLANE_CB: begin
				left_mb[`IP_CHROMA_N-1:0] = cb_q;
			end
			PLANE_CR: begin
				left_mb[`IP_CHROMA_N-1:0] = cr_q;
			end
			default: begin
				left_mb = '0;
			end
		endcase
	end

endmodule

/* source/intra_pred_regs.sv */
//****************************************
// intra prediction register file, top
// no handshake, all writes are ena strobes
// corner and up-right pixels are not held
//****************************************
`timescale 1ns/1ps
`include "intra_pred_consts.svh"

module intra_pred_regs (
	input logic clk,
	input logic rst_n,
	input logic ena,
	input logic [`IP_BLK_CNT_W-1:0] blk4x4_counter,
	input intra_pred_pkg::pred_wr_t pred_wr,
	input intra_pred_pkg::quad_wr_t up_wr,
	input intra_pred_pkg::left_wr_t left_wr,
	input logic [`IP_PRELOAD_W-1:0] preload_counter,
	input intra_pred_pkg::line_ram_t line_ram,
	output intra_pred_pkg::pixel_blk_t intra_pred,
	output intra_pred_pkg::pixel_blk_t up_mb,
	output intra_pred_pkg::pixel_blk_t left_mb
);
	import intra_pred_pkg::*;

	plane_e plane;

	// 0..15 luma, 16..19 Cb, 20.. Cr
	always_comb begin
		if (blk4x4_counter < `IP_BLK_CNT_W'(`IP_CB_FIRST)) begin
			plane = PLANE_LUMA;
		end else if (blk4x4_counter < `IP_BLK_CNT_W'(`IP_CR_FIRST)) begin
			plane = PLANE_CB;
		end else begin
			plane = PLANE_CR;
		end
	end

	//****************************************
	// stores
	//****************************************
	intra_pred_block_buf u_block_buf (
		.clk        (clk),
		.rst_n      (rst_n),
		.ena        (ena),
		.pred_wr    (pred_wr),
		.intra_pred (intra_pred)
	);

	intra_pred_up_nb u_up_nb (
		.clk             (clk),
		.rst_n           (rst_n),
		.ena             (ena),
		.preload_counter (preload_counter),
		.line_ram        (line_ram),
		.up_wr           (up_wr),
		.plane           (plane),
		.up_mb           (up_mb)
	);

	intra_pred_left_nb u_left_nb (
		.clk     (clk),
		.rst_n   (rst_n),
		.ena     (ena),
		.left_wr (left_wr),
		.plane   (plane),
		.left_mb (left_mb)
	);

endmodule

/* verification/intra_pred_chk.sv */
//****************************************
// assertions bound into intra_pred_regs
// sampled on the rising clock edge
//****************************************
`timescale 1ns/1ps
`include "intra_pred_consts.svh"

module intra_pred_chk (
	input logic clk,
	input logic rst_n,
	input logic ena,
	input intra_pred_pkg::pred_wr_t pred_wr,
	input intra_pred_pkg::plane_e plane,
	input intra_pred_pkg::pixel_blk_t intra_pred,
	input intra_pred_pkg::pixel_blk_t up_mb,
	input intra_pred_pkg::pixel_blk_t left_mb
);
	import intra_pred_pkg::*;

	a_chroma_upper_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(plane != PLANE_LUMA) |-> (up_mb[`IP_BLK_N-1:`IP_CHROMA_N] == '0 &&
		left_mb[`IP_BLK_N-1:`IP_CHROMA_N] == '0))
		else $error("chroma edge has nonzero upper half");

	// every pixel equals the p0 of the fill command
	a_dc_fill: assert property (@(posedge clk) disable iff (!rst_n)
		(ena && pred_wr.cmd == PRED_DC) |=>
		(intra_pred == {`IP_BLK_N{$past(pred_wr.data.p0)}}))
		else $error("prediction block does not hold the DC value");

	a_reset_zero: assert property (@(posedge clk)
		!rst_n |-> (intra_pred == '0 && up_mb == '0 && left_mb == '0))
		else $error("output nonzero during reset");

endmodule

bind intra_pred_regs intra_pred_chk chk0 (
	.clk        (clk),
	.rst_n      (rst_n),
	.ena        (ena),
	.pred_wr    (pred_wr),
	.plane      (plane),
	.intra_pred (intra_pred),
	.up_mb      (up_mb),
	.left_mb    (left_mb)
);

/* verification/intra_pred_tb.sv */
//****************************************
// table-driven testbench for the registers
// expected values come from a model run
// over the whole table before the stimulus
//****************************************
`timescale 1ns/1ps
`include "intra_pred_consts.svh"

module intra_pred_tb;
	import intra_pred_pkg::*;

	localparam int MAX_ROWS = 128;
	localparam int CLK_NS = 20;
	localparam int RST_CYCLES = 16;

	typedef struct packed {
		logic check;
		logic ena;
		logic [`IP_BLK_CNT_W-1:0] blk_cnt;
		logic [`IP_PRELOAD_W-1:0] pre_cnt;
		pred_wr_t pred_wr;
		quad_wr_t up_wr;
		left_wr_t left_wr;
		line_ram_t line_ram;
		pixel_blk_t exp_pred;
		pixel_blk_t exp_up;
		pixel_blk_t exp_left;
	} row_t;

	logic clk;
	logic rst_n;
	logic ena;
	logic [`IP_BLK_CNT_W-1:0] blk4x4_counter;
	logic [`IP_PRELOAD_W-1:0] preload_counter;
	pred_wr_t pred_wr;
	quad_wr_t up_wr;
	left_wr_t left_wr;
	line_ram_t line_ram;
	pixel_blk_t intra_pred;
	pixel_blk_t up_mb;
	pixel_blk_t left_mb;

	row_t rows [MAX_ROWS];
	int n_rows;
	int err_count;
	logic table_ready;

	// model state, index 0 is pixel 0
	pixel_t m_pred [`IP_BLK_N] = '{default: '0};
	pixel_t m_up_y [`IP_BLK_N] = '{default: '0};
	pixel_t m_up_cb [`IP_CHROMA_N] = '{default: '0};
	pixel_t m_up_cr [`IP_CHROMA_N] = '{default: '0};
	pixel_t m_left_y [`IP_BLK_N] = '{default: '0};
	pixel_t m_left_cb [`IP_CHROMA_N] = '{default: '0};
	pixel_t m_left_cr [`IP_CHROMA_N] = '{default: '0};

	intra_pred_regs dut0 (
		.clk             (clk),
		.rst_n           (rst_n),
		.ena             (ena),
		.blk4x4_counter  (blk4x4_counter),
		.pred_wr         (pred_wr),
		.up_wr           (up_wr),
		.left_wr         (left_wr),
		.preload_counter (preload_counter),
		.line_ram        (line_ram),
		.intra_pred      (intra_pred),
		.up_mb           (up_mb),
		.left_mb         (left_mb)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	function automatic quad_t rand_quad();
		quad_t q;
		q = $urandom();
		return q;
	endfunction

	function automatic pixel_t quad_pix(input quad_t q, input int r);
		case (r)
			0: return q.p0;
			1: return q.p1;
			2: return q.p2;
			default: return q.p3;
		endcase
	endfunction

	function automatic row_t make_row(input logic en, input int blk, input int pre,
		input pred_cmd_e cmd, input int col, input logic up_en, input int up_addr,
		input logic left_en, input plane_e target, input int left_addr);
		row_t r;
		r = '0;
		r.check = 1'b1;
		r.ena = en;
		r.blk_cnt = `IP_BLK_CNT_W'(blk);
		r.pre_cnt = `IP_PRELOAD_W'(pre);
		r.pred_wr.cmd = cmd;
		r.pred_wr.col = 2'(col);
		r.pred_wr.data = rand_quad();
		r.up_wr.wr = up_en;
		r.up_wr.addr = 2'(up_addr);
		r.up_wr.data = rand_quad();
		r.left_wr.target = target;
		r.left_wr.row.wr = left_en;
		r.left_wr.row.addr = 2'(left_addr);
		r.left_wr.row.data = rand_quad();
		r.line_ram.luma = rand_quad();
		r.line_ram.cb = rand_quad();
		r.line_ram.cr = rand_quad();
		return r;
	endfunction

	task automatic add_row(input row_t r);
		rows[n_rows] = r;
		n_rows++;
	endtask

	// neighbour edge as seen for a given block count
	function automatic pixel_blk_t edge_out(input pixel_t y [`IP_BLK_N],
		input pixel_t cb [`IP_CHROMA_N], input pixel_t cr [`IP_CHROMA_N], input int blk);
		pixel_blk_t e;
		e = '0;
		for (int k = 0; k < `IP_BLK_N; k++) begin
			if (blk < `IP_CB_FIRST) begin
				e[k] = y[k];
			end else if (k < `IP_CHROMA_N) begin
				e[k] = (blk < `IP_CR_FIRST) ? cb[k] : cr[k];
			end
		end
		return e;
	endfunction

	task automatic apply_model(input int i);
		row_t r;
		int pre;
		int base;
		r = rows[i];
		pre = int'(r.pre_cnt);
		if (r.ena) begin
			for (int k = 0; k < `IP_QUAD_N; k++) begin
				if (r.pred_wr.cmd == PRED_COLUMN) begin
					m_pred[4 * k + 3 - int'(r.pred_wr.col)] = quad_pix(r.pred_wr.data, k);
				end
				if (pre >= 1 && pre <= 4) begin
					m_up_y[4 * (4 - pre) + k] = quad_pix(r.line_ram.luma, k); // preload first
				end else if (r.up_wr.wr) begin
					m_up_y[4 * int'(r.up_wr.addr) + k] = quad_pix(r.up_wr.data, k);
				end
				if (pre == 1 || pre == 2) begin
					base = (pre == 2) ? 0 : 4;
					m_up_cb[base + k] = quad_pix(r.line_ram.cb, k);
					m_up_cr[base + k] = quad_pix(r.line_ram.cr, k);
				end
				if (r.left_wr.row.wr) begin
					base = 4 * int'(r.left_wr.row.addr);
					case (r.left_wr.target)
						PLANE_LUMA: m_left_y[base + k] = quad_pix(r.left_wr.row.data, k);
						PLANE_CB: m_left_cb[base % 8 + k] = quad_pix(r.left_wr.row.data, k);
						default: m_left_cr[base % 8 + k] = quad_pix(r.left_wr.row.data, k);
					endcase
				end
			end
			if (r.pred_wr.cmd == PRED_DC) begin
				for (int k = 0; k < `IP_BLK_N; k++) begin
					m_pred[k] = r.pred_wr.data.p0;
				end
			end
		end
		for (int k = 0; k < `IP_BLK_N; k++) begin
			rows[i].exp_pred[k] = m_pred[k];
		end
		rows[i].exp_up = edge_out(m_up_y, m_up_cb, m_up_cr, int'(r.blk_cnt));
		rows[i].exp_left = edge_out(m_left_y, m_left_cb, m_left_cr, int'(r.blk_cnt));
	endtask

	task automatic build_table();
		int views [3] = '{3, 17, 22};                 // luma, Cb, Cr
		add_row(make_row(1'b0, 0, 4, PRED_DC, 0, 1'b1, 0, 1'b1, PLANE_LUMA, 0));
		for (int c = 0; c < 4; c++) begin
			add_row(make_row(1'b1, 0, 0, PRED_COLUMN, c, 1'b0, 0, 1'b0, PLANE_LUMA, 0));
		end
		add_row(make_row(1'b1, 0, 0, PRED_DC, 1, 1'b0, 0, 1'b0, PLANE_LUMA, 0));
		add_row(make_row(1'b1, 0, 0, PRED_COLUMN, 2, 1'b0, 0, 1'b0, PLANE_LUMA, 0));
		for (int p = 4; p >= 1; p--) begin
			add_row(make_row(1'b1, 3, p, PRED_NONE, 0, 1'b0, 0, 1'b0, PLANE_LUMA, 0));
		end
		for (int a = 0; a < 4; a++) begin
			add_row(make_row(1'b1, 3, 0, PRED_NONE, 0, 1'b1, a, 1'b0, PLANE_LUMA, 0));
		end
		add_row(make_row(1'b1, 3, 3, PRED_NONE, 0, 1'b1, 1, 1'b0, PLANE_LUMA, 0));
		add_row(make_row(1'b1, 3, 1, PRED_NONE, 0, 1'b1, 0, 1'b0, PLANE_LUMA, 0));
		for (int p = 5; p < 8; p++) begin
			add_row(make_row(1'b1, 17, p, PRED_NONE, 0, 1'b0, 0, 1'b0, PLANE_LUMA, 0));
		end
		add_row(make_row(1'b0, 3, 2, PRED_DC, 0, 1'b1, 2, 1'b1, PLANE_LUMA, 1));
		add_row(make_row(1'b1, 17, 2, PRED_NONE, 0, 1'b0, 0, 1'b0, PLANE_LUMA, 0));
		add_row(make_row(1'b1, 22, 1, PRED_NONE, 0, 1'b0, 0, 1'b0, PLANE_LUMA, 0));
		add_row(make_row(1'b0, 17, 1, PRED_NONE, 0, 1'b0, 0, 1'b1, PLANE_CB, 1));
		for (int t = 0; t < 3; t++) begin
			for (int a = 0; a < 4; a++) begin
				add_row(make_row(1'b1, views[t], 0, PRED_NONE, 0, 1'b0, 0, 1'b1,
					plane_e'(t), a));
			end
		end
		for (int t = 0; t < 3; t++) begin
			add_row(make_row(1'b1, views[t], 0, PRED_NONE, 0, 1'b0, 0, 1'b0, PLANE_LUMA, 0));
		end
		// random mix of everything, ena low about a quarter of the time
		for (int n = 0; n < 40; n++) begin
			add_row(make_row($urandom_range(0, 3) != 0, int'($urandom_range(0, 31)),
				int'($urandom_range(0, 7)), pred_cmd_e'($urandom_range(0, 2)),
				int'($urandom_range(0, 3)), $urandom_range(0, 1) != 0,
				int'($urandom_range(0, 3)), $urandom_range(0, 1) != 0,
				plane_e'($urandom_range(0, 2)), int'($urandom_range(0, 3))));
		end
	endtask

	task automatic check_eq(input string what, input pixel_blk_t got, input pixel_blk_t exp);
		if (got !== exp) begin
			err_count++;
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_row(input int i);
		check_eq($sformatf("row %0d intra_pred", i), intra_pred, rows[i].exp_pred);
		check_eq($sformatf("row %0d up_mb", i), up_mb, rows[i].exp_up);
		check_eq($sformatf("row %0d left_mb", i), left_mb, rows[i].exp_left);
	endtask

	task automatic drive_row(input row_t r);
		ena = r.ena;
		blk4x4_counter = r.blk_cnt;
		preload_counter = r.pre_cnt;
		pred_wr = r.pred_wr;
		up_wr = r.up_wr;
		left_wr = r.left_wr;
		line_ram = r.line_ram;
	endtask

	initial begin
		void'($urandom(84));
		err_count = 0;
		n_rows = 0;
		table_ready = 1'b0;
		rst_n = 1'b0;
		drive_row('0);
		build_table();
		for (int i = 0; i < n_rows; i++) begin
			apply_model(i);
		end
		table_ready = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		check_eq("intra_pred after reset", intra_pred, '0);
		check_eq("up_mb after reset", up_mb, '0);
		check_eq("left_mb after reset", left_mb, '0);
		for (int i = 0; i <= n_rows; i++) begin
			@(posedge clk);
			#2;
			if (i > 0) begin
				if (rows[i - 1].check) begin
					check_row(i - 1);
				end
			end
			if (i < n_rows) begin
				drive_row(rows[i]);
			end
		end
		if (err_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// twice the table length plus reset
	initial begin
		wait (table_ready);
		#(n_rows * CLK_NS * 2 + RST_CYCLES * CLK_NS);
		$display("timeout: the stimulus table did not finish in time");
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

/* intra_pred_regs.f */
+incdir+include
source/intra_pred_pkg.sv
source/intra_pred_block_buf.sv
source/intra_pred_up_nb.sv
source/intra_pred_left_nb.sv
source/intra_pred_regs.sv
verification/intra_pred_chk.sv
verification/intra_pred_tb.sv

/* Makefile */
# Verilator build, run and lint for the intra prediction registers

VERILATOR ?= verilator
TOP       ?= intra_pred_tb
FILELIST  ?= intra_pred_regs.f
FLAGS     ?= --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the pass message shows up in the output
run: build
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

lint:
	$(VERILATOR) --lint-only --timing $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
